// File: files.f
lsu_pkg.sv
lsu_xfer_if.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_fsm.sv
lsu_top.sv
tb_mem_model.sv
tb_lsu.sv

// File: lsu_fsm.sv
// bus request controller
// split detection, five-state request FSM, first-half error and error address
module lsu_fsm import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // core request
  input  logic                 lsu_req_i,
  input  logic                 lsu_we_i,
  input  lsu_type_e            lsu_type_i,
  input  logic                 lsu_sign_ext_i,
  input  logic [AddrWidth-1:0] lsu_addr_i,
  // bus handshake
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  output logic                 data_req_o,
  output logic [AddrWidth-1:0] data_addr_o,
  output logic                 second_half_o,
  lsu_xfer_if.ctrl             xfer,
  // core status
  output logic                 lsu_req_done_o,
  output logic                 lsu_resp_valid_o,
  output logic                 lsu_rdata_valid_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic [AddrWidth-1:0] lsu_err_addr_o,
  output logic                 busy_o
);

  ls_fsm_e                ls_fsm_cs, ls_fsm_ns;
  logic [OffsetWidth-1:0] offset;
  logic                   split_access;
  // high from the first grant to the second grant of a split access
  logic                   handle_mis_q, handle_mis_d;
  // first half error, valid once its response arrived
  logic                   lsu_err_q, lsu_err_d;
  logic                   we_q;
  // the second word address is the current one
  logic                   addr_incr;
  logic                   ctrl_update, addr_update, rdata_update;
  // request address, later the second address or the first failing one
  logic [AddrWidth-1:0]   addr_last_q, addr_last_d;
  logic [AddrWidth-1:0]   addr_second;
  logic                   any_err;

  assign offset = lsu_addr_i[OffsetWidth-1:0];

  // misaligned word, or half word running off the end of the word
  assign split_access = ((lsu_type_i == LSU_WORD) && (offset != '0)) ||
                        ((lsu_type_i == LSU_HALF) && (offset == '1));

  assign addr_second = {addr_last_q[AddrWidth-1:OffsetWidth] + 1'b1, {OffsetWidth{1'b0}}};

  //////////////////////////////////////////////////////////////
  // request FSM
  //////////////////////////////////////////////////////////////

  always_comb begin
    ls_fsm_ns    = ls_fsm_cs;
    data_req_o   = 1'b0;
    addr_incr    = 1'b0;
    handle_mis_d = handle_mis_q;
    lsu_err_d    = lsu_err_q;
    addr_update  = 1'b0;
    rdata_update = 1'b0;
    unique case (ls_fsm_cs)
      IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            addr_update  = 1'b1;
            handle_mis_d = split_access;
            ls_fsm_ns    = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            ls_fsm_ns = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end
      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          addr_update  = 1'b1;
          handle_mis_d = 1'b1;
          ls_fsm_ns    = WAIT_RVALID_MIS;
        end
      end
      WAIT_RVALID_MIS: begin
        // second half goes out while the first response is pending
        data_req_o = 1'b1;
        addr_incr  = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d    = data_err_i;
          rdata_update = ~we_q;
          // keep the first failing address
          addr_update  = data_gnt_i & ~data_err_i;
          handle_mis_d = ~data_gnt_i;
          ls_fsm_ns    = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          handle_mis_d = 1'b0;
          ls_fsm_ns    = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end
      WAIT_GNT: begin
        // aligned access, or second half after the first response
        data_req_o = 1'b1;
        addr_incr  = handle_mis_q;
        if (data_gnt_i) begin
          addr_update  = ~lsu_err_q;
          handle_mis_d = 1'b0;
          ls_fsm_ns    = IDLE;
        end
      end
      WAIT_RVALID_MIS_GNTS_DONE: begin
        // both granted, first response still owed
        addr_incr = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d    = data_err_i;
          addr_update  = ~data_err_i;
          rdata_update = ~we_q;
          ls_fsm_ns    = IDLE;
        end
      end
      default: begin
        ls_fsm_ns = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs    <= IDLE;
      handle_mis_q <= 1'b0;
      lsu_err_q    <= 1'b0;
    end else begin
      ls_fsm_cs    <= ls_fsm_ns;
      handle_mis_q <= handle_mis_d;
      lsu_err_q    <= lsu_err_d;
    end
  end

  //////////////////////////////////////////////////////////////
  // transfer attributes and error address
  //////////////////////////////////////////////////////////////

  // first grant of each access, second half reuses them
  assign ctrl_update = data_req_o & data_gnt_i & ~handle_mis_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xfer.offset_q   <= '0;
      xfer.type_q     <= LSU_WORD;
      xfer.sign_ext_q <= 1'b0;
      we_q            <= 1'b0;
    end else if (ctrl_update) begin
      xfer.offset_q   <= offset;
      xfer.type_q     <= lsu_type_i;
      xfer.sign_ext_q <= lsu_sign_ext_i;
      we_q            <= lsu_we_i;
    end
  end

  assign xfer.rdata_update = rdata_update;

  // core may drop its address after done, so the second word comes from here
  assign addr_last_d = addr_incr ? addr_second : lsu_addr_i;

  always_ff @(posedge clk_i) begin
    if (addr_update) begin
      addr_last_q <= addr_last_d;
    end
  end

  //////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////

  assign data_addr_o   = addr_incr ? addr_second
                                   : {lsu_addr_i[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
  assign second_half_o = handle_mis_q;

  // last grant of the access
  assign lsu_req_done_o = data_req_o & data_gnt_i & (handle_mis_q | ~split_access);

  // idle means no first-half response is still owed
  assign any_err           = lsu_err_q | data_err_i;
  assign lsu_resp_valid_o  = data_rvalid_i & (ls_fsm_cs == IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~any_err & ~we_q;
  assign load_err_o        = lsu_resp_valid_o & any_err & ~we_q;
  assign store_err_o       = lsu_resp_valid_o & any_err & we_q;
  assign lsu_err_addr_o    = addr_last_q;
  assign busy_o            = (ls_fsm_cs != IDLE);

  state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ls_fsm_cs inside {IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT, WAIT_RVALID_MIS_GNTS_DONE}
  ) else $error("illegal controller state");

  addr_word_aligned: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_addr_o[OffsetWidth-1:0] == '0)
  ) else $error("bus request with unaligned address");

endmodule

// File: lsu_load_align.sv
// load side realignment
// first-half data register, word merge and zero/sign extension
module lsu_load_align import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  lsu_xfer_if.align            xfer,
  input  logic [DataWidth-1:0] rdata_i,
  output logic [DataWidth-1:0] rdata_o
);

  // upper three bytes of the first half response
  logic [DataWidth-1:8]   rdata_q;
  // first half bytes placed below the current response
  logic [2*DataWidth-1:0] rdata_cat;
  // realigned word, half word and byte
  logic [DataWidth-1:0]   rdata_w;
  logic [15:0]            rdata_h;
  logic [7:0]             rdata_b;

  //////////////////////////////////////////////////////////////
  // first half capture
  //////////////////////////////////////////////////////////////

  // lane 0 of the first half never belongs to a split access
  always_ff @(posedge clk_i) begin
    if (xfer.rdata_update) begin
      rdata_q <= rdata_i[DataWidth-1:8];
    end
  end

  //////////////////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////////////////

  // bytes of the request start at lane offset of this concatenation
  assign rdata_cat = {rdata_i, rdata_q, 8'h00};

  // offset 0 is a single aligned word, no merge
  always_comb begin
    if (xfer.offset_q == '0) begin
      rdata_w = rdata_i;
    end else begin
      rdata_w = rdata_cat[{xfer.offset_q, 3'b000} +: DataWidth];
    end
  end

  // only offset 3 crosses into the second word
  always_comb begin
    if (xfer.offset_q == '1) begin
      rdata_h = rdata_cat[{xfer.offset_q, 3'b000} +: 16];
    end else begin
      rdata_h = rdata_i[{xfer.offset_q, 3'b000} +: 16];
    end
  end

  assign rdata_b = rdata_i[{xfer.offset_q, 3'b000} +: 8];

  //////////////////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////////////////

  always_comb begin
    unique case (xfer.type_q)
      LSU_WORD: rdata_o = rdata_w;
      LSU_HALF: rdata_o = {{(DataWidth-16){xfer.sign_ext_q & rdata_h[15]}}, rdata_h};
      default:  rdata_o = {{(DataWidth-8){xfer.sign_ext_q & rdata_b[7]}}, rdata_b};
    endcase
  end

  // the mux selects come from controller registers and must stay known
  offset_type_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({xfer.offset_q, xfer.type_q})
  ) else $error("load aligner selects unknown");

endmodule

// File: lsu_pkg.sv
// shared widths and enumerations of the load/store unit
// access type encoding and controller states
package lsu_pkg;

  //////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////

  // byte address of the core and the bus
  localparam int unsigned AddrWidth   = 32;
  // bus data word
  localparam int unsigned DataWidth   = 32;
  // one enable per byte lane
  localparam int unsigned BeWidth     = DataWidth / 8;
  // byte position within a word
  localparam int unsigned OffsetWidth = $clog2(BeWidth);

  //////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////

  // access size as sent by the core, both upper codes mean byte
  typedef enum logic [1:0] {
    LSU_WORD     = 2'b00,
    LSU_HALF     = 2'b01,
    LSU_BYTE     = 2'b10,
    LSU_BYTE_ALT = 2'b11
  } lsu_type_e;

  // bus request sequencing
  // _MIS states belong to the first half of a split access
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } ls_fsm_e;

endpackage

// File: lsu_store_align.sv
// store side lane handling
// byte enable generation per half and store data rotation
module lsu_store_align import lsu_pkg::*; (
  input  lsu_type_e              type_i,
  input  logic [OffsetWidth-1:0] offset_i,
  input  logic                   second_half_i,
  input  logic [DataWidth-1:0]   wdata_i,
  output logic [BeWidth-1:0]     be_o,
  output logic [DataWidth-1:0]   wdata_o
);

  // enables for an access at offset 0
  logic [BeWidth-1:0]     be_base;
  // enables over two words, low word is the first half
  logic [2*BeWidth-1:0]   be_span;
  // store word doubled so a shift acts as a rotate
  logic [2*DataWidth-1:0] wdata_dbl;

  //////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////

  always_comb begin
    unique case (type_i)
      LSU_WORD: be_base = {BeWidth{1'b1}};
      LSU_HALF: be_base = BeWidth'(2'b11);
      default:  be_base = BeWidth'(1'b1);
    endcase
  end

  // bytes pushed past lane 3 spill into the next word
  // e.g. word at offset 1 -> 1110 then 0001
  assign be_span = {{BeWidth{1'b0}}, be_base} << offset_i;
  assign be_o    = second_half_i ? be_span[2*BeWidth-1:BeWidth] : be_span[BeWidth-1:0];

  //////////////////////////////////////////////////////////////
  // store data
  //////////////////////////////////////////////////////////////

  // rotate left by offset bytes
  // spilled bytes wrap to the low lanes, which the second half writes
  assign wdata_dbl = {wdata_i, wdata_i} << {offset_i, 3'b000};
  assign wdata_o   = wdata_dbl[2*DataWidth-1:DataWidth];

  // a first half always writes at least one byte, whatever type and offset
  always_comb begin
    if (!second_half_i && !$isunknown(offset_i)) begin
      assert (be_o != '0)
        else $error("first half access without byte enables");
    end
  end

endmodule

// File: lsu_top.sv
// load/store unit top level
// controller, store aligner and load aligner between core and data bus
module lsu_top import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // core side
  input  logic                 lsu_req_i,
  input  logic                 lsu_we_i,
  input  lsu_type_e            lsu_type_i,
  input  logic                 lsu_sign_ext_i,
  input  logic [AddrWidth-1:0] lsu_addr_i,
  input  logic [DataWidth-1:0] lsu_wdata_i,
  output logic [DataWidth-1:0] lsu_rdata_o,
  output logic                 lsu_req_done_o,
  output logic                 lsu_resp_valid_o,
  output logic                 lsu_rdata_valid_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic [AddrWidth-1:0] lsu_err_addr_o,
  output logic                 busy_o,
  // data bus
  output logic                 data_req_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  output logic [AddrWidth-1:0] data_addr_o,
  output logic                 data_we_o,
  output logic [BeWidth-1:0]   data_be_o,
  output logic [DataWidth-1:0] data_wdata_o,
  input  logic [DataWidth-1:0] data_rdata_i
);

  // high while the second word of a split access is requested
  logic second_half;

  lsu_xfer_if xfer ();

  //////////////////////////////////////////////////////////////
  // controller
  //////////////////////////////////////////////////////////////

  lsu_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_type_i        (lsu_type_i),
    .lsu_sign_ext_i    (lsu_sign_ext_i),
    .lsu_addr_i        (lsu_addr_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .data_req_o        (data_req_o),
    .data_addr_o       (data_addr_o),
    .second_half_o     (second_half),
    .xfer              (xfer.ctrl),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .lsu_err_addr_o    (lsu_err_addr_o),
    .busy_o            (busy_o)
  );

  //////////////////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////////////////

  // core holds type and address for both halves of a store
  lsu_store_align u_store_align (
    .type_i        (lsu_type_i),
    .offset_i      (lsu_addr_i[OffsetWidth-1:0]),
    .second_half_i (second_half),
    .wdata_i       (lsu_wdata_i),
    .be_o          (data_be_o),
    .wdata_o       (data_wdata_o)
  );

  lsu_load_align u_load_align (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .xfer    (xfer.align),
    .rdata_i (data_rdata_i),
    .rdata_o (lsu_rdata_o)
  );

  assign data_we_o = lsu_we_i;

endmodule

// File: lsu_xfer_if.sv
// transfer attributes from the controller to the load aligner
// registered at each granted access, plus the first-half capture strobe
interface lsu_xfer_if import lsu_pkg::*; ();

  // byte offset of the original request
  logic [OffsetWidth-1:0] offset_q;
  // word, half word or byte
  lsu_type_e              type_q;
  // sign extend half word and byte loads
  logic                   sign_ext_q;
  // first half response of a split load is on the bus
  logic                   rdata_update;

  // controller side drives everything
  modport ctrl (
    output offset_q, type_q, sign_ext_q, rdata_update
  );

  // load aligner only looks
  modport align (
    input offset_q, type_q, sign_ext_q, rdata_update
  );

endinterface

// File: run_sim.sh
#!/bin/sh
# build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f files.f -o sim_lsu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
exit 1

// File: tb_lsu.sv
// testbench for the load/store unit
// stimulus table with shadow memory, bus side checks, reset checks and cycle limit
module tb_lsu import lsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // one row of the stimulus table
  typedef struct packed {
    logic                 we;
    lsu_type_e            typ;
    logic                 sign_ext;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic                 exp_err;
  } entry_t;

  logic                 clk_i;
  logic                 rst_ni;
  // core side
  logic                 lsu_req;
  logic                 lsu_we;
  lsu_type_e            lsu_type;
  logic                 lsu_sign_ext;
  logic [AddrWidth-1:0] lsu_addr;
  logic [DataWidth-1:0] lsu_wdata;
  logic [DataWidth-1:0] lsu_rdata;
  logic                 req_done;
  logic                 resp_valid;
  logic                 rdata_valid;
  logic                 load_err;
  logic                 store_err;
  logic [AddrWidth-1:0] err_addr;
  logic                 busy;
  // data bus
  logic                 data_req;
  logic                 data_gnt;
  logic                 data_rvalid;
  logic                 data_err;
  logic [AddrWidth-1:0] data_addr;
  logic                 data_we;
  logic [BeWidth-1:0]   data_be;
  logic [DataWidth-1:0] data_wdata;
  logic [DataWidth-1:0] data_rdata;

  entry_t      tests [$];
  // expected memory contents with one byte per address
  logic [7:0]  shadow [64];
  int unsigned errors     = 0;
  int unsigned checks     = 0;
  int unsigned cycles     = 0;
  int unsigned max_cycles = 0;

  always #2 clk_i = ~clk_i;

  lsu_top uut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req),
    .lsu_we_i          (lsu_we),
    .lsu_type_i        (lsu_type),
    .lsu_sign_ext_i    (lsu_sign_ext),
    .lsu_addr_i        (lsu_addr),
    .lsu_wdata_i       (lsu_wdata),
    .lsu_rdata_o       (lsu_rdata),
    .lsu_req_done_o    (req_done),
    .lsu_resp_valid_o  (resp_valid),
    .lsu_rdata_valid_o (rdata_valid),
    .load_err_o        (load_err),
    .store_err_o       (store_err),
    .lsu_err_addr_o    (err_addr),
    .busy_o            (busy),
    .data_req_o        (data_req),
    .data_gnt_i        (data_gnt),
    .data_rvalid_i     (data_rvalid),
    .data_err_i        (data_err),
    .data_addr_o       (data_addr),
    .data_we_o         (data_we),
    .data_be_o         (data_be),
    .data_wdata_o      (data_wdata),
    .data_rdata_i      (data_rdata)
  );

  tb_mem_model u_mem (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (data_req),
    .addr_i   (data_addr),
    .we_i     (data_we),
    .be_i     (data_be),
    .wdata_i  (data_wdata),
    .gnt_o    (data_gnt),
    .rvalid_o (data_rvalid),
    .err_o    (data_err),
    .rdata_o  (data_rdata)
  );

  ////////////////////////////////////////////////////////////
  // expected values
  ////////////////////////////////////////////////////////////

  function automatic int unsigned access_size(input lsu_type_e typ);
    case (typ)
      LSU_WORD: return 4;
      LSU_HALF: return 2;
      default:  return 1;
    endcase
  endfunction

  // little endian bytes from the shadow with zero or sign extension
  function automatic logic [DataWidth-1:0] expected_load(input entry_t e);
    logic [DataWidth-1:0] val;
    int unsigned          size;
    val  = '0;
    size = access_size(e.typ);
    for (int unsigned k = 0; k < size; k++) begin
      val[8*k +: 8] = shadow[6'(e.addr + k)];
    end
    if (e.sign_ext && val[8*size-1]) begin
      for (int unsigned k = size; k < 4; k++) begin
        val[8*k +: 8] = 8'hff;
      end
    end
    return val;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
      end
  endtask

  // address, byte enables, direction and store lanes of one granted half
  task automatic check_grant(input entry_t e, input int unsigned half);
    logic [BeWidth-1:0]   exp_be;
    logic [DataWidth-1:0] exp_wdata;
    logic [DataWidth-1:0] lane_mask;
    logic [AddrWidth-1:0] byte_addr;
    exp_be    = '0;
    exp_wdata = '0;
    lane_mask = '0;
    for (int unsigned k = 0; k < access_size(e.typ); k++) begin
      byte_addr = e.addr + k;
      // byte k goes out with this half when it lies in its word
      if ((byte_addr >> 2) == (e.addr >> 2) + half) begin
        exp_be[byte_addr[1:0]]            = 1'b1;
        exp_wdata[8*byte_addr[1:0] +: 8] = e.wdata[8*k +: 8];
        lane_mask[8*byte_addr[1:0] +: 8] = 8'hff;
      end
    end
    compare_value("data_addr_o", data_addr, ((e.addr >> 2) + half) << 2);
    compare_value("data_be_o", 32'(data_be), 32'(exp_be));
    compare_value("data_we_o", 32'(data_we), 32'(e.we));
    if (e.we) begin
      compare_value("data_wdata_o lanes", data_wdata & lane_mask, exp_wdata);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic add_entry(input logic we, input lsu_type_e typ, input logic sign_ext,
                           input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] wdata, input logic exp_err);
    entry_t e;
    e.we       = we;
    e.typ      = typ;
    e.sign_ext = sign_ext;
    e.addr     = addr;
    e.wdata    = wdata;
    e.exp_err  = exp_err;
    tests.push_back(e);
  endtask

  task automatic apply_entry(input entry_t e);
    int unsigned          grants;
    int unsigned          exp_grants;
    logic                 seen;
    logic [AddrWidth-1:0] byte_addr;
    grants     = 0;
    byte_addr  = e.addr + access_size(e.typ) - 1;
    exp_grants = ((byte_addr >> 2) != (e.addr >> 2)) ? 2 : 1;
    @(posedge clk_i);
    #1;
    lsu_req      = 1'b1;
    lsu_we       = e.we;
    lsu_type     = e.typ;
    lsu_sign_ext = e.sign_ext;
    lsu_addr     = e.addr;
    lsu_wdata    = e.wdata;
    // request phase up to the last grant
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      if (data_req && data_gnt) begin
        check_grant(e, grants);
        grants++;
      end
      // done marks the last grant and nothing else
      compare_value("lsu_req_done_o", 32'(req_done),
                    32'(data_req && data_gnt && (grants == exp_grants)));
      seen = req_done;
    end
    compare_value("grant count", grants, exp_grants);
    @(posedge clk_i);
    #1;
    lsu_req = 1'b0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      seen = resp_valid;
    end
    compare_value("load_err_o", 32'(load_err), 32'(!e.we && e.exp_err));
    compare_value("store_err_o", 32'(store_err), 32'(e.we && e.exp_err));
    compare_value("lsu_rdata_valid_o", 32'(rdata_valid), 32'(!e.we && !e.exp_err));
    if (e.exp_err) begin
      // the access address if the first word errs and the second word address otherwise
      compare_value("lsu_err_addr_o", err_addr,
                    (e.addr[5:2] >= 4'd12) ? e.addr : ((e.addr >> 2) + 1) << 2);
    end
    if (!e.we && !e.exp_err) begin
      compare_value("lsu_rdata_o", lsu_rdata, expected_load(e));
    end
    if (e.we) begin
      for (int unsigned k = 0; k < access_size(e.typ); k++) begin
        byte_addr = e.addr + k;
        if (byte_addr[5:2] < 4'd12) begin
          shadow[byte_addr[5:0]] = e.wdata[8*k +: 8];
        end
      end
    end
  endtask

  // run limit of 40 cycles per table row plus reset
  always @(posedge clk_i) begin
    if (cycles > max_cycles) begin
      $display("timeout: run exceeded %0d cycles without finishing", max_cycles);
      $display("tests failed");
      $finish;
    end else begin
      cycles <= cycles + 1;
    end
  end

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    lsu_req      = 1'b0;
    lsu_we       = 1'b0;
    lsu_type     = LSU_WORD;
    lsu_sign_ext = 1'b0;
    lsu_addr     = '0;
    lsu_wdata    = '0;
    // same fill as the memory model
    for (int unsigned a = 0; a < 64; a++) begin
      shadow[a] = 8'(a * 29 + 7);
    end
    //        we    type          sext  addr    wdata         err
    add_entry(1'b1, LSU_WORD,     1'b0, 32'h04, 32'hdeadbeef, 1'b0);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h04, 32'h0,        1'b0);
    add_entry(1'b0, LSU_BYTE,     1'b1, 32'h08, 32'h0,        1'b0);
    add_entry(1'b0, LSU_BYTE,     1'b0, 32'h08, 32'h0,        1'b0);
    add_entry(1'b0, LSU_BYTE,     1'b0, 32'h09, 32'h0,        1'b0);
    add_entry(1'b0, LSU_BYTE,     1'b1, 32'h0a, 32'h0,        1'b0);
    add_entry(1'b0, LSU_BYTE_ALT, 1'b1, 32'h0b, 32'h0,        1'b0);
    add_entry(1'b0, LSU_HALF,     1'b1, 32'h0c, 32'h0,        1'b0);
    add_entry(1'b0, LSU_HALF,     1'b0, 32'h0d, 32'h0,        1'b0);
    add_entry(1'b0, LSU_HALF,     1'b1, 32'h0e, 32'h0,        1'b0);
    add_entry(1'b0, LSU_HALF,     1'b1, 32'h0f, 32'h0,        1'b0);
    // misaligned word stores and loads at offsets 1 to 3
    add_entry(1'b1, LSU_WORD,     1'b0, 32'h11, 32'h11223344, 1'b0);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h11, 32'h0,        1'b0);
    add_entry(1'b1, LSU_WORD,     1'b0, 32'h16, 32'ha5c30f96, 1'b0);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h16, 32'h0,        1'b0);
    add_entry(1'b1, LSU_WORD,     1'b0, 32'h1b, 32'h80706050, 1'b0);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h1b, 32'h0,        1'b0);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h10, 32'h0,        1'b0);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h14, 32'h0,        1'b0);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h18, 32'h0,        1'b0);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h1c, 32'h0,        1'b0);
    // half word across a word boundary
    add_entry(1'b1, LSU_HALF,     1'b0, 32'h23, 32'h0000beef, 1'b0);
    add_entry(1'b0, LSU_HALF,     1'b1, 32'h23, 32'h0,        1'b0);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h20, 32'h0,        1'b0);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h24, 32'h0,        1'b0);
    add_entry(1'b1, LSU_BYTE,     1'b0, 32'h26, 32'h0000009a, 1'b0);
    add_entry(1'b0, LSU_BYTE,     1'b1, 32'h26, 32'h0,        1'b0);
    // error region in the first half or only in the second half
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h30, 32'h0,        1'b1);
    add_entry(1'b1, LSU_WORD,     1'b0, 32'h34, 32'h01020304, 1'b1);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h2e, 32'h0,        1'b1);
    add_entry(1'b1, LSU_WORD,     1'b0, 32'h2d, 32'hc0ffee11, 1'b1);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h2c, 32'h0,        1'b0);
    add_entry(1'b0, LSU_HALF,     1'b0, 32'h2f, 32'h0,        1'b1);
    add_entry(1'b0, LSU_WORD,     1'b0, 32'h31, 32'h0,        1'b1);
    add_entry(1'b0, LSU_BYTE,     1'b0, 32'h3a, 32'h0,        1'b1);
    max_cycles = 40 * tests.size() + 8;
    // no bus or status activity while reset is held
    repeat (4) begin
      @(negedge clk_i);
      compare_value("data_req_o in reset", 32'(data_req), 32'd0);
      compare_value("busy_o in reset", 32'(busy), 32'd0);
      compare_value("lsu_resp_valid_o in reset", 32'(resp_valid), 32'd0);
    end
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int unsigned i = 0; i < tests.size(); i++) begin
      apply_entry(tests[i]);
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tb_mem_model.sv
// data bus responder for the testbench
// 16-word memory, random grant and response delays, error region at words 12 to 15
module tb_mem_model import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic                 we_i,
  input  logic [BeWidth-1:0]   be_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output logic                 err_o,
  output logic [DataWidth-1:0] rdata_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [DataWidth-1:0] mem [16];
  // pending responses in grant order
  logic [DataWidth-1:0] fifo_data [4];
  logic                 fifo_err [4];
  int unsigned          fifo_due [4];
  logic [1:0]           wr_ptr;
  logic [1:0]           rd_ptr;
  int unsigned          count;
  int unsigned          cycle;
  int unsigned          last_due;
  int unsigned          next_due;
  // cycles left before the next grant
  int unsigned          gnt_wait;
  int                   seed = 50;
  logic [3:0]           idx;
  logic                 hit_err;

  assign idx      = addr_i[5:2];
  assign hit_err  = (idx >= 4'd12);
  assign gnt_o    = req_i && (gnt_wait == 0);
  // head of the queue goes out once its cycle has come
  assign rvalid_o = (count != 0) && (fifo_due[rd_ptr] <= cycle);
  assign err_o    = rvalid_o && fifo_err[rd_ptr];
  assign rdata_o  = fifo_data[rd_ptr];

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // byte at address a holds a*29+7, odd factor so every byte differs
      for (int i = 0; i < 16; i++) begin
        for (int b = 0; b < 4; b++) begin
          mem[i][8*b +: 8] <= 8'((4*i + b) * 29 + 7);
        end
      end
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= 0;
      cycle    <= 0;
      last_due <= 0;
      gnt_wait <= 0;
    end else begin
      cycle <= cycle + 1;
      if (rvalid_o) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (req_i && gnt_o) begin
        // zero to two idle cycles, never two responses in one cycle
        next_due = cycle + 1 + ($unsigned($random(seed)) % 3);
        if (next_due <= last_due) begin
          next_due = last_due + 1;
        end
        fifo_data[wr_ptr] <= mem[idx];
        fifo_err[wr_ptr]  <= hit_err;
        fifo_due[wr_ptr]  <= next_due;
        last_due          <= next_due;
        wr_ptr            <= wr_ptr + 1'b1;
        // error region ignores writes
        if (we_i && !hit_err) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[b]) begin
              mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
          end
        end
        gnt_wait <= $unsigned($random(seed)) % 3;
      end else if (req_i && (gnt_wait != 0)) begin
        gnt_wait <= gnt_wait - 1;
      end
      count <= count + int'(req_i && gnt_o) - int'(rvalid_o);
    end
  end

endmodule
